//--- fp_noncomp_slice.f
+incdir+src
src/fp_slice_pkg.sv
src/fp_lane_pipe.sv
src/fp_noncomp_lane.sv
src/fp_result_assembly.sv
src/fp_noncomp_slice.sv
verif/fp_noncomp_slice_tb.sv

//--- Makefile
# Verilator simulation of the non-computational FP slice

TOOL      ?= verilator
TOP       ?= fp_noncomp_slice_tb
FILELIST  ?= fp_noncomp_slice.f
FLAGS     ?= --binary --timing --assert --top-module $(TOP)
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "TEST PASSED"; \
	else \
	  echo "TEST FAILED"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/fp_noncomp_slice_tb.sv
`include "fp_slice_macros.svh"

module fp_noncomp_slice_tb import fp_slice_pkg::*; ();

  localparam int N_LAT   = 20;
  localparam int N_OP    = 60;
  localparam int N_BP    = 150;
  localparam int N_TOTAL = N_LAT + 4 * N_OP + N_BP;
  localparam int CLK_P   = 4;

  typedef struct packed {
    logic [`FP_WIDTH-1:0] result;
    logic                 invalid;
    logic [`FP_TAG_W-1:0] tag;
  } expect_t;

  logic                 clk_i;
  logic                 rst_i;
  slice_req_t           req_i;
  logic                 in_valid_i;
  logic                 in_ready_o;
  logic                 out_ready_i;
  logic [`FP_WIDTH-1:0] result_o;
  logic                 invalid_o;
  logic [`FP_TAG_W-1:0] tag_o;
  logic                 out_valid_o;
  logic                 busy_o;

  integer  seed = 32'ha45b_243e;
  bit      bp_on;
  bit      lat_check;           // Exact latency expected, output never stalled
  int      cycle = 0;
  string   cur_test;
  expect_t exp_q[$];
  int      acc_q[$];            // Accept cycle of each outstanding request
  int      sb_checks = 0;       // Scoreboard side counters
  int      sb_errors = 0;
  int      sb_outs = 0;
  int      main_checks = 0;     // Directed check counters
  int      main_errors = 0;
  int      chk0, err0, outs0;
  int      n_tests = 0;
  int      total_checks = 0;
  int      total_errors = 0;

  fp_noncomp_slice fp_noncomp_slice_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .invalid_o   (invalid_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o),
    .busy_o      (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_P / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  // One lane at FP16 (half) or FP32 width, operands right aligned
  function automatic logic [31:0] lane_ref(input logic [31:0] a, input logic [31:0] b,
                                           input fp_op_e op, input bit half, output bit nv);
    int          man_w;
    logic [31:0] sign_bit, mant_mask, exp_mask, quiet_bit, mask, key_a, key_b;
    bit          a_nan, b_nan, a_snan, b_snan;
    man_w     = half ? 10 : 23;
    mask      = half ? 32'h0000_ffff : 32'hffff_ffff;
    sign_bit  = half ? 32'h0000_8000 : 32'h8000_0000;
    mant_mask = (32'h1 << man_w) - 1;
    exp_mask  = (sign_bit - 1) & ~mant_mask;
    quiet_bit = 32'h1 << (man_w - 1);
    a_nan     = ((a & exp_mask) == exp_mask) && ((a & mant_mask) != 0);
    b_nan     = ((b & exp_mask) == exp_mask) && ((b & mant_mask) != 0);
    a_snan    = a_nan && ((a & quiet_bit) == 0);
    b_snan    = b_nan && ((b & quiet_bit) == 0);
    nv        = 1'b0;
    case (op)
      OP_SGNJ:  return (a & ~sign_bit) | (b & sign_bit);
      OP_SGNJN: return (a & ~sign_bit) | (~b & sign_bit);
      OP_SGNJX: return a ^ (b & sign_bit);
      default: begin
        nv = a_snan || b_snan;
        if (a_nan && b_nan) return half ? {16'h0, `CANON_NAN16} : `CANON_NAN32;
        if (a_nan) return b;
        if (b_nan) return a;
        // Monotonic key, so -0 sorts just below +0
        key_a = (a & sign_bit) != 0 ? (~a & mask) : (a | sign_bit);
        key_b = (b & sign_bit) != 0 ? (~b & mask) : (b | sign_bit);
        if (op == OP_MIN) return (key_a <= key_b) ? a : b;
        return (key_a >= key_b) ? a : b;
      end
    endcase
  endfunction

  function automatic expect_t ref_slice(input slice_req_t req);
    expect_t     e;
    bit          nv0, nv1;
    logic [31:0] r0, r1;
    e.tag = req.tag;
    if (req.fmt == FMT_FP32) begin
      e.result  = lane_ref(req.op_a, req.op_b, req.op, 1'b0, nv0);
      e.invalid = nv0 & req.mask[0];
    end else begin
      r0 = lane_ref({16'h0, req.op_a[15:0]}, {16'h0, req.op_b[15:0]}, req.op, 1'b1, nv0);
      r1 = lane_ref({16'h0, req.op_a[31:16]}, {16'h0, req.op_b[31:16]}, req.op, 1'b1, nv1);
      if (req.vec) begin
        e.result  = {r1[15:0], r0[15:0]};
        e.invalid = (nv0 & req.mask[0]) | (nv1 & req.mask[1]);
      end else begin
        e.result  = {16'hffff, r0[15:0]}; // NaN-boxed
        e.invalid = nv0 & req.mask[0];
      end
    end
    return e;
  endfunction

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  function automatic logic [15:0] pick_half(input logic [15:0] other);
    logic [31:0] r;
    logic [31:0] v;
    r = $random(seed);
    v = $random(seed);
    case (r[2:0])
      3'd0:    return {v[15], 5'h1f, 1'b1, v[8:0]};       // Quiet NaN
      3'd1:    return {v[15], 5'h1f, 1'b0, v[8:1], 1'b1}; // Signalling NaN
      3'd2:    return 16'h0000;
      3'd3:    return 16'h8000;
      3'd4:    return other;
      default: return v[15:0];
    endcase
  endfunction

  function automatic logic [31:0] pick_word(input logic [31:0] other);
    logic [31:0] r;
    logic [31:0] v;
    r = $random(seed);
    v = $random(seed);
    case (r[2:0])
      3'd0:    return {v[31], 8'hff, 1'b1, v[21:0]};
      3'd1:    return {v[31], 8'hff, 1'b0, v[21:1], 1'b1};
      3'd2:    return 32'h0000_0000;
      3'd3:    return 32'h8000_0000;
      3'd4:    return other;
      default: return v;
    endcase
  endfunction

  // fmt_mode 0 FP32, 1 scalar FP16, 2 vector FP16, 3 any
  // op_mode 0 min/max, 1 sign injection, 2 any
  task automatic build_req(input int fmt_mode, input int op_mode, output slice_req_t req);
    logic [31:0] r;
    int          sel;
    int          opsel;
    r        = $random(seed);
    sel      = (fmt_mode == 3) ? (r[1:0] % 3) : fmt_mode;
    req.fmt  = (sel == 0) ? FMT_FP32 : FMT_FP16;
    req.vec  = (sel == 2) ? 1'b1 : ((sel == 1) ? 1'b0 : r[2]); // Don't care for FP32
    req.mask = r[4:3];
    req.tag  = r[8:5];
    opsel    = (op_mode == 0) ? r[9] : (op_mode == 1) ? 2 + (r[11:10] % 3) : (r[12:10] % 5);
    case (opsel)
      0:       req.op = OP_MIN;
      1:       req.op = OP_MAX;
      2:       req.op = OP_SGNJ;
      3:       req.op = OP_SGNJN;
      default: req.op = OP_SGNJX;
    endcase
    req.op_a = $random(seed);
    req.op_b = $random(seed);
    if (req.fmt == FMT_FP32) begin
      req.op_a = pick_word(req.op_b);
      req.op_b = pick_word(req.op_a);
    end else begin
      req.op_a[15:0] = pick_half(req.op_b[15:0]);
      req.op_b[15:0] = pick_half(req.op_a[15:0]);
      if (req.vec) begin
        req.op_a[31:16] = pick_half(req.op_b[31:16]);
        req.op_b[31:16] = pick_half(req.op_a[31:16]);
      end
    end
  endtask

  // Called 1 unit after a rising edge, returns at the same point
  task automatic send_req(input slice_req_t req);
    req_i      = req;
    in_valid_i = 1'b1;
    @(negedge clk_i);
    while (!in_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    in_valid_i = 1'b0;
  endtask

  // Random output stall, drawn on the edge and applied just after it
  initial begin : backpressure
    logic [31:0] r;
    out_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      r = $random(seed);
      #1;
      out_ready_i = bp_on ? r[0] : 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Scoreboard, sampled on the falling edge where all is settled
  // ------------------------------------------------------------
  task automatic report_value(input string field, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    $display("Fail %s %s: expected %h, actual %h", cur_test, field, exp_v, act_v);
    sb_errors++;
  endtask

  always @(negedge clk_i) begin : scoreboard
    expect_t exp_v;
    int      acc_c;
    if (!rst_i) begin
      // Requests still queued are exactly the items held in the pipeline
      if ((in_valid_i && in_ready_o) || (out_valid_o && out_ready_i)) begin
        sb_checks++;
        assert (busy_o == (exp_q.size() != 0))
          else report_value("busy_o", 32'(exp_q.size() != 0), 32'(busy_o));
      end
      if (in_valid_i && in_ready_o) begin
        exp_q.push_back(ref_slice(req_i));
        acc_q.push_back(cycle);
      end
      if (out_valid_o && out_ready_i) begin
        sb_outs++;
        sb_checks++;
        assert (exp_q.size() != 0) else begin
          $display("Unexpected output in %s: no request was outstanding", cur_test);
          sb_errors++;
        end
        if (exp_q.size() != 0) begin
          exp_v = exp_q.pop_front();
          acc_c = acc_q.pop_front();
          assert (result_o == exp_v.result) else report_value("result", exp_v.result, result_o);
          assert (invalid_o == exp_v.invalid)
            else report_value("invalid", 32'(exp_v.invalid), 32'(invalid_o));
          assert (tag_o == exp_v.tag) else report_value("tag", 32'(exp_v.tag), 32'(tag_o));
          if (lat_check) begin
            assert (cycle - acc_c == `FP_PIPE_REGS)
              else report_value("latency", `FP_PIPE_REGS, cycle - acc_c);
          end
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Test sequencing
  // ------------------------------------------------------------
  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    main_checks++;
    assert (act_v === exp_v) else begin
      $display("Fail %s %s: expected %0b, actual %0b", cur_test, name, exp_v, act_v);
      main_errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    chk0     = sb_checks + main_checks;
    err0     = sb_errors + main_errors;
    outs0    = sb_outs;
  endtask

  task automatic end_test();
    int checks;
    int errors;
    checks = sb_checks + main_checks - chk0;
    errors = sb_errors + main_errors - err0;
    $display("Test %s finished: %0d checks, %0d errors", cur_test, checks, errors);
    n_tests++;
    total_checks += checks;
    total_errors += errors;
  endtask

  task automatic run_test(input string name, input int count, input int fmt_mode,
                          input int op_mode, input bit bp);
    slice_req_t req;
    begin_test(name);
    bp_on = bp;
    @(posedge clk_i);
    #1;
    for (int i = 0; i < count; i++) begin
      build_req(fmt_mode, op_mode, req);
      send_req(req);
    end
    while (exp_q.size() != 0 || busy_o) @(negedge clk_i); // Drain
    main_checks++;
    assert (sb_outs - outs0 == count) else begin
      $display("Result count wrong in %s: %0d sent, %0d received", name, count, sb_outs - outs0);
      main_errors++;
    end
    end_test();
  endtask

  initial begin : watchdog
    #((N_TOTAL * (`FP_PIPE_REGS + 8) + 10 + 200) * CLK_P);
    $display("Watchdog expired: the tests did not finish in the expected time");
    $display("Errors found");
    $finish;
  end

  initial begin : main
    rst_i      = 1'b1;
    in_valid_i = 1'b0;
    req_i      = '0;
    bp_on      = 1'b0;
    lat_check  = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    begin_test("reset");
    @(negedge clk_i);
    check_flag("out_valid_o", 1'b0, out_valid_o);
    check_flag("busy_o", 1'b0, busy_o);
    check_flag("in_ready_o", 1'b1, in_ready_o);
    end_test();

    lat_check = 1'b1;
    run_test("latency", N_LAT, 3, 2, 1'b0);
    lat_check = 1'b0;
    run_test("fp32_minmax", N_OP, 0, 0, 1'b1);
    run_test("fp16_scalar", N_OP, 1, 2, 1'b1);
    run_test("fp16_vector", N_OP, 2, 2, 1'b1);
    run_test("sign_inject", N_OP, 3, 1, 1'b1);
    run_test("backpressure", N_BP, 3, 2, 1'b1);

    $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- src/fp_noncomp_slice.sv
`include "fp_slice_macros.svh"

module fp_noncomp_slice import fp_slice_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  slice_req_t           req_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic                 out_ready_i,
  output logic [`FP_WIDTH-1:0] result_o,
  output logic                 invalid_o,
  output logic [`FP_TAG_W-1:0] tag_o,
  output logic                 out_valid_o,
  output logic                 busy_o
);

  logic                              vec16_req;    // Request uses both lanes
  logic                              head_vec16;   // Lane 0 head uses both lanes
  logic [`FP_NUM_LANES-1:0]          lane_in_valid, lane_in_ready;
  logic [`FP_NUM_LANES-1:0]          lane_out_valid, lane_out_ready, lane_busy;
  lane_payload_t [`FP_NUM_LANES-1:0] lane_payload;
  logic [`FP_WIDTH-1:0]              opa_hi, opb_hi;

  // ------------------------------------------------------------
  // Input side
  // ------------------------------------------------------------
  assign vec16_req = req_i.vec & (req_i.fmt == FMT_FP16);
  assign opa_hi    = req_i.op_a >> `FP16_WIDTH;
  assign opb_hi    = req_i.op_b >> `FP16_WIDTH;

  assign lane_in_valid[0] = in_valid_i;
  // Upper lane only takes the request together with lane 0
  assign lane_in_valid[1] = in_valid_i & vec16_req & lane_in_ready[0];
  assign in_ready_o       = lane_in_ready[0];

  // ------------------------------------------------------------
  // Lanes
  // ------------------------------------------------------------
  fp_noncomp_lane lane_0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .opa_i       (req_i.op_a),
    .opb_i       (req_i.op_b),
    .op_i        (req_i.op),
    .fmt_i       (req_i.fmt),
    .vec_i       (req_i.vec),
    .mask_i      (req_i.mask[0]),
    .tag_i       (req_i.tag),
    .in_valid_i  (lane_in_valid[0]),
    .in_ready_o  (lane_in_ready[0]),
    .out_ready_i (lane_out_ready[0]),
    .payload_o   (lane_payload[0]),
    .out_valid_o (lane_out_valid[0]),
    .busy_o      (lane_busy[0])
  );

  fp_noncomp_lane lane_1 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .opa_i       (opa_hi),
    .opb_i       (opb_hi),
    .op_i        (req_i.op),
    .fmt_i       (req_i.fmt),
    .vec_i       (req_i.vec),
    .mask_i      (req_i.mask[1]),
    .tag_i       (req_i.tag),
    .in_valid_i  (lane_in_valid[1]),
    .in_ready_o  (lane_in_ready[1]),
    .out_ready_i (lane_out_ready[1]),
    .payload_o   (lane_payload[1]),
    .out_valid_o (lane_out_valid[1]),
    .busy_o      (lane_busy[1])
  );

  // ------------------------------------------------------------
  // Output side
  // ------------------------------------------------------------
  assign head_vec16        = lane_payload[0].vec & (lane_payload[0].fmt == FMT_FP16);
  assign lane_out_ready[0] = out_ready_i;
  assign lane_out_ready[1] = out_ready_i & head_vec16; // Pop upper lane only for vectors

  fp_result_assembly u_assembly (
    .lane0_i   (lane_payload[0]),
    .lane1_i   (lane_payload[1]),
    .result_o  (result_o),
    .invalid_o (invalid_o),
    .tag_o     (tag_o)
  );

  assign out_valid_o = lane_out_valid[0];
  assign busy_o      = |lane_busy;

  a_lane1_follows: assert property (@(posedge clk_i) disable iff (rst_i)
    lane_out_valid[1] |-> lane_out_valid[0])
    else $error("Upper lane holds a result without lane 0");

  a_lane1_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    in_valid_i && vec16_req && lane_in_ready[0] |-> lane_in_ready[1])
    else $error("Upper lane not ready for a vector request");

endmodule

//--- src/fp_result_assembly.sv
`include "fp_slice_macros.svh"

module fp_result_assembly import fp_slice_pkg::*; (
  input  lane_payload_t        lane0_i,
  input  lane_payload_t        lane1_i,
  output logic [`FP_WIDTH-1:0] result_o,
  output logic                 invalid_o,
  output logic [`FP_TAG_W-1:0] tag_o
);

  localparam int unsigned H = `FP16_WIDTH;

  logic                                   is_vec16;
  lane_payload_t [`FP_NUM_LANES-1:0]      lanes;
  logic          [`FP_NUM_LANES-1:0]      lane_used;

  // Lane 0 carries the format and vector info of the head item
  assign is_vec16 = lane0_i.vec & (lane0_i.fmt == FMT_FP16);

  // ------------------------------------------------------------
  // Result packing
  // ------------------------------------------------------------
  always_comb begin : pack_result
    if (lane0_i.fmt == FMT_FP32) begin
      result_o = lane0_i.result;
    end else if (is_vec16) begin
      result_o = {lane1_i.result[H-1:0], lane0_i.result[H-1:0]};
    end else begin
      result_o = {{H{1'b1}}, lane0_i.result[H-1:0]}; // NaN-box scalar FP16
    end
  end

  // ------------------------------------------------------------
  // Status collapse under the SIMD mask
  // ------------------------------------------------------------
  assign lanes     = {lane1_i, lane0_i};
  assign lane_used = {is_vec16, 1'b1}; // Upper lane only for vectors

  always_comb begin : collapse_status
    invalid_o = 1'b0;
    for (int i = 0; i < `FP_NUM_LANES; i++) begin
      invalid_o = invalid_o | (lanes[i].nv & lanes[i].mask & lane_used[i]);
    end
  end

  assign tag_o = lane0_i.tag; // Upper lane tag is a copy

endmodule

//--- src/fp_noncomp_lane.sv
`include "fp_slice_macros.svh"

module fp_noncomp_lane import fp_slice_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [`FP_WIDTH-1:0] opa_i,
  input  logic [`FP_WIDTH-1:0] opb_i,
  input  fp_op_e               op_i,
  input  fp_fmt_e              fmt_i,
  input  logic                 vec_i,
  input  logic                 mask_i,
  input  logic [`FP_TAG_W-1:0] tag_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic                 out_ready_i,
  output lane_payload_t        payload_o,
  output logic                 out_valid_o,
  output logic                 busy_o
);

  localparam int unsigned PAD_W   = `FP_WIDTH - `FP16_WIDTH;
  localparam int unsigned MAN16_W = 10;
  localparam int unsigned MAN32_W = 23;

  typedef struct packed {
    logic                 sign;
    logic                 nan;
    logic                 snan;
    logic                 zero;
    logic [`FP_WIDTH-2:0] mag; // Magnitude, zero-extended for FP16
  } op_class_t;

  // Classify one operand at the width of the selected format
  function automatic op_class_t classify(input logic [`FP_WIDTH-1:0] op, input fp_fmt_e fmt);
    op_class_t c;
    logic      exp_ones;
    logic      man_nz;
    logic      quiet;
    if (fmt == FMT_FP16) begin
      c.sign   = op[`FP16_WIDTH-1];
      c.mag    = {{PAD_W{1'b0}}, op[`FP16_WIDTH-2:0]};
      exp_ones = &op[`FP16_WIDTH-2:MAN16_W];
      man_nz   = |op[MAN16_W-1:0];
      quiet    = op[MAN16_W-1];
    end else begin
      c.sign   = op[`FP_WIDTH-1];
      c.mag    = op[`FP_WIDTH-2:0];
      exp_ones = &op[`FP_WIDTH-2:MAN32_W];
      man_nz   = |op[MAN32_W-1:0];
      quiet    = op[MAN32_W-1];
    end
    c.nan  = exp_ones & man_nz;
    c.snan = c.nan & ~quiet; // MSB of mantissa clear
    c.zero = (c.mag == '0);
    return c;
  endfunction

  op_class_t            a_c, b_c;
  logic [`FP_WIDTH-1:0] opa_fmt, opb_fmt, canon_nan;
  logic                 a_lt_b;
  logic                 inj_sign;
  lane_payload_t        payload_d;

  // ------------------------------------------------------------
  // Operand decode
  // ------------------------------------------------------------
  assign a_c = classify(opa_i, fmt_i);
  assign b_c = classify(opb_i, fmt_i);

  assign opa_fmt   = (fmt_i == FMT_FP16) ? {{PAD_W{1'b0}}, opa_i[`FP16_WIDTH-1:0]} : opa_i;
  assign opb_fmt   = (fmt_i == FMT_FP16) ? {{PAD_W{1'b0}}, opb_i[`FP16_WIDTH-1:0]} : opb_i;
  assign canon_nan = (fmt_i == FMT_FP16) ? {{PAD_W{1'b0}}, `CANON_NAN16} : `CANON_NAN32;

  // Total order on non-NaN values, -0 below +0
  always_comb begin : compare
    if (a_c.zero && b_c.zero) begin
      a_lt_b = a_c.sign & ~b_c.sign;
    end else if (a_c.sign != b_c.sign) begin
      a_lt_b = a_c.sign;
    end else if (a_c.sign) begin
      a_lt_b = a_c.mag > b_c.mag; // Larger negative magnitude is smaller
    end else begin
      a_lt_b = a_c.mag < b_c.mag;
    end
  end

  // ------------------------------------------------------------
  // Operation select
  // ------------------------------------------------------------
  always_comb begin : op_select
    payload_d      = '0;
    payload_d.mask = mask_i;
    payload_d.fmt  = fmt_i;
    payload_d.vec  = vec_i;
    payload_d.tag  = tag_i;
    inj_sign       = b_c.sign;
    unique case (op_i)
      OP_MIN, OP_MAX: begin
        payload_d.nv = a_c.snan | b_c.snan;
        if (a_c.nan && b_c.nan) begin
          payload_d.result = canon_nan;
        end else if (a_c.nan) begin
          payload_d.result = opb_fmt; // Non-NaN operand wins
        end else if (b_c.nan) begin
          payload_d.result = opa_fmt;
        end else if ((op_i == OP_MIN) == a_lt_b) begin
          payload_d.result = opa_fmt;
        end else begin
          payload_d.result = opb_fmt;
        end
      end
      OP_SGNJ, OP_SGNJN, OP_SGNJX: begin
        if (op_i == OP_SGNJN) begin
          inj_sign = ~b_c.sign;
        end else if (op_i == OP_SGNJX) begin
          inj_sign = a_c.sign ^ b_c.sign;
        end
        if (fmt_i == FMT_FP16) begin
          payload_d.result = {{PAD_W{1'b0}}, inj_sign, a_c.mag[`FP16_WIDTH-2:0]};
        end else begin
          payload_d.result = {inj_sign, a_c.mag};
        end
      end
      default: payload_d.result = '0;
    endcase
  end

  fp_lane_pipe u_pipe (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .data_i      (payload_d),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .data_o      (payload_o),
    .busy_o      (busy_o)
  );

  // Head item has a defined format
  a_head_fmt: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o |-> (payload_o.fmt inside {FMT_FP32, FMT_FP16}))
    else $error("Lane head payload has an illegal format");

endmodule

//--- src/fp_lane_pipe.sv
`include "fp_slice_macros.svh"

module fp_lane_pipe import fp_slice_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          in_valid_i,
  output logic          in_ready_o,
  input  lane_payload_t data_i,
  output logic          out_valid_o,
  input  logic          out_ready_i,
  output lane_payload_t data_o,
  output logic          busy_o
);

  localparam int unsigned N = `FP_PIPE_REGS;

  logic [N-1:0]  valid_q;
  lane_payload_t data_q [N];
  logic [N-1:0]  valid_in;  // What each stage would load
  lane_payload_t data_in [N];
  logic [N:0]    rdy;       // rdy[i] lets stage i load

  // ------------------------------------------------------------
  // Stage inputs and backward ready chain
  // ------------------------------------------------------------
  always_comb begin : stage_inputs
    valid_in[0] = in_valid_i;
    data_in[0]  = data_i;
    for (int i = 1; i < N; i++) begin
      valid_in[i] = valid_q[i-1];
      data_in[i]  = data_q[i-1];
    end
  end

  always_comb begin : ready_chain
    rdy[N] = out_ready_i;
    for (int i = N - 1; i >= 0; i--) begin
      rdy[i] = rdy[i+1] | ~valid_q[i]; // Stage empty or being drained
    end
  end

  // ------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < N; i++) begin
      if (rst_i) begin
        valid_q[i] <= 1'b0;
      end else if (rdy[i]) begin
        valid_q[i] <= valid_in[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < N; i++) begin
      if (rdy[i] && valid_in[i]) data_q[i] <= data_in[i]; // Only real items load
    end
  end

  assign in_ready_o  = rdy[0];
  assign out_valid_o = valid_q[N-1];
  assign data_o      = data_q[N-1];
  assign busy_o      = |valid_q;

  a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(data_o))
    else $error("Lane output changed while stalled");

endmodule

//--- src/fp_slice_pkg.sv
`include "fp_slice_macros.svh"

package fp_slice_pkg;

  // ------------------------------------------------------------
  // Formats and operations
  // ------------------------------------------------------------
  typedef enum logic {
    FMT_FP32 = 1'b0, // Single lane, full word
    FMT_FP16 = 1'b1  // Low half, or both lanes when vectorial
  } fp_fmt_e;

  typedef enum logic [2:0] {
    OP_MIN   = 3'd0,
    OP_MAX   = 3'd1,
    OP_SGNJ  = 3'd2, // Sign of b
    OP_SGNJN = 3'd3, // Inverted sign of b
    OP_SGNJX = 3'd4  // XOR of both signs
  } fp_op_e;

  // ------------------------------------------------------------
  // Payloads
  // ------------------------------------------------------------
  // Carried by every stage of a lane pipeline
  typedef struct packed {
    logic [`FP_WIDTH-1:0] result;
    logic                 nv;   // Invalid operation
    logic                 mask; // SIMD mask bit of this lane
    fp_fmt_e              fmt;
    logic                 vec;
    logic [`FP_TAG_W-1:0] tag;
  } lane_payload_t;

  // Request as seen at the slice input
  typedef struct packed {
    logic [`FP_WIDTH-1:0]     op_a;
    logic [`FP_WIDTH-1:0]     op_b;
    fp_op_e                   op;
    fp_fmt_e                  fmt;
    logic                     vec;
    logic [`FP_NUM_LANES-1:0] mask;
    logic [`FP_TAG_W-1:0]     tag;
  } slice_req_t;

endpackage

//--- src/fp_slice_macros.svh
`ifndef FP_SLICE_MACROS_SVH
`define FP_SLICE_MACROS_SVH

// ------------------------------------------------------------
// Datapath geometry
// ------------------------------------------------------------
`define FP_WIDTH      32 // One full slice word
`define FP16_WIDTH    16 // Half-precision lane width
`define FP_NUM_LANES  2  // FP16 vector fills two lanes

// ------------------------------------------------------------
// Pipeline and side-band
// ------------------------------------------------------------
`define FP_PIPE_REGS  2 // Register stages per lane
`define FP_TAG_W      4 // Tag carried with each request

// ------------------------------------------------------------
// Canonical quiet NaNs
// ------------------------------------------------------------
// Returned by min/max when both inputs are NaN
`define CANON_NAN32   32'h7FC0_0000
`define CANON_NAN16   16'h7E00

`endif
